// File: Makefile
# Verilator build and run of the audio filter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = audio_filter_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/audio_filter_pkg.sv
/*
 * Shared definitions for the audio filter core
 *   sample, 2.16 fixed-point and product widths
 *   tap and sequencer state enums
 *   per-cycle MAC step and input history structs
 */

`default_nettype none

package audio_filter_pkg;

	// Widths ----------------------------------------------------------
	localparam int SAMPLE_W = 16;	// Codec sample
	localparam int FIX_W    = 18;	// 2.16 format
	localparam int FRAC_W   = 16;	// Fraction bits of fix_t

	typedef logic signed [SAMPLE_W-1:0] sample_t;	// Port-level audio
	typedef logic signed [FIX_W-1:0]    fix_t;	// Values, coeffs, accumulators
	typedef logic signed [2*FIX_W-1:0]  prod_t;	// Full multiplier result

	// Five taps of one second-order section
	typedef enum logic [2:0] {
		TAP_B1,	// b1 * x(n)
		TAP_B2,	// b2 * x(n-1)
		TAP_B3,	// b3 * x(n-2)
		TAP_A2,	// -a2 * y(n-1)
		TAP_A3	// -a3 * y(n-2)
	} tap_t;

	// Sequencer states, tap states in tap order
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_B1,
		ST_B2,
		ST_B3,
		ST_A2,
		ST_A3,
		ST_UPDATE
	} seq_state_t;

	// Control word broadcast to both sections
	typedef struct packed {
		logic active;	// Tap issued this cycle
		tap_t tap;
		logic update;	// Shift histories, store result
	} mac_step_t;

	// Shared input history, x_n on top
	typedef struct packed {
		fix_t x_n;
		fix_t x_n1;
		fix_t x_n2;
	} x_hist_t;

endpackage

`default_nettype wire

// File: hdl/audio_filter_top.sv
/*
 * Audio filter core top level
 *   sequencer, shared input history
 *   lowpass section to the left output, bandpass to the right
 *   output scaling and inversion
 */

`timescale 1ns/1ns
`default_nettype none

module audio_filter_top
	import audio_filter_pkg::*;
#(
	// Butterworth lowpass, cutoff 0.1
	parameter fix_t LP_B1    = 18'h0_0524,
	parameter fix_t LP_B2    = 18'h0_0A48,
	parameter fix_t LP_B3    = 18'h0_0524,
	parameter fix_t LP_A2    = 18'h1_8F9E,
	parameter fix_t LP_A3    = 18'h3_5BD1,
	parameter int   LP_SHIFT = 0,
	// Butterworth bandpass 0.1 to 0.15, halved coeffs
	parameter fix_t BP_B1    = 18'h0_0956,
	parameter fix_t BP_B2    = 18'h0_0000,
	parameter fix_t BP_B3    = 18'h3_F6AA,
	parameter fix_t BP_A2    = 18'h0_DBEF,
	parameter fix_t BP_A3    = 18'h3_92AE,
	parameter int   BP_SHIFT = 1
)
(
	input  logic    AUD_CTRL_CLK,
	input  logic    reset,
	input  logic    dac_lrck,	// LR clock level
	input  sample_t audio_in,
	output sample_t audio_out_l,	// Lowpass
	output sample_t audio_out_r	// Bandpass
);

	mac_step_t step;
	logic      capture;
	x_hist_t   hist;
	fix_t      lp_y, bp_y;

	filter_sequencer u_sequencer (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.dac_lrck     (dac_lrck),
		.step         (step),
		.capture      (capture)
	);

	sample_history u_history (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.capture      (capture),
		.update       (step.update),
		.audio_in     (audio_in),
		.hist         (hist)
	);

	// ------------------------------------------------------------------
	// Filter sections
	// ------------------------------------------------------------------
	biquad_mac #(
		.B1 (LP_B1), .B2 (LP_B2), .B3 (LP_B3),
		.A2 (LP_A2), .A3 (LP_A3), .OUT_SHIFT (LP_SHIFT)
	) u_lowpass (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.step         (step),
		.hist         (hist),
		.y_out        (lp_y)
	);

	biquad_mac #(
		.B1 (BP_B1), .B2 (BP_B2), .B3 (BP_B3),
		.A2 (BP_A2), .A3 (BP_A3), .OUT_SHIFT (BP_SHIFT)
	) u_bandpass (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.step         (step),
		.hist         (hist),
		.y_out        (bp_y)
	);

	// Drop the two guard LSBs, codec path inverts so negate here
	assign audio_out_l = -lp_y[FIX_W-1 -: SAMPLE_W];
	assign audio_out_r = -bp_y[FIX_W-1 -: SAMPLE_W];

endmodule

`default_nettype wire

// File: hdl/biquad_mac.sv
/*
 * One second-order IIR section
 *   per-tap coefficient and operand select, registered
 *   2.16 signed multiplier and accumulator
 *   output history y(n-1), y(n-2) with optional doubling
 */

`timescale 1ns/1ns
`default_nettype none

module biquad_mac
	import audio_filter_pkg::*;
#(
	parameter fix_t B1        = '0,
	parameter fix_t B2        = '0,
	parameter fix_t B3        = '0,
	parameter fix_t A2        = '0,	// Already negated
	parameter fix_t A3        = '0,	// Already negated
	parameter int   OUT_SHIFT = 0	// 1 when coeffs are stored at half scale
)
(
	input  logic      AUD_CTRL_CLK,
	input  logic      reset,
	input  mac_step_t step,
	input  x_hist_t   hist,
	output fix_t      y_out
);

	fix_t  coeff_sel, value_sel;	// Tap mux
	fix_t  coeff_q, value_q;	// Multiplier operands
	logic  acc_en;	// Product valid this cycle
	logic  acc_first;	// B1 product, restart the sum
	prod_t prod;
	fix_t  prod_fix;	// Product back in 2.16
	fix_t  acc;
	fix_t  y_n1, y_n2;	// Own output history

	// ------------------------------------------------------------------
	// Operand select
	// ------------------------------------------------------------------
	always_comb
	begin
		case (step.tap)
			TAP_B1:  begin coeff_sel = B1; value_sel = hist.x_n;  end
			TAP_B2:  begin coeff_sel = B2; value_sel = hist.x_n1; end
			TAP_B3:  begin coeff_sel = B3; value_sel = hist.x_n2; end
			TAP_A2:  begin coeff_sel = A2; value_sel = y_n1;      end
			default: begin coeff_sel = A3; value_sel = y_n2;      end
		endcase
	end

	// 2.16 x 2.16 gives 4.32, keep sign and the next 17 bits
	assign prod     = coeff_q * value_q;
	assign prod_fix = {prod[2*FIX_W-1], prod[FIX_W+FRAC_W-2:FRAC_W]};

	assign y_out = y_n1;

	// ------------------------------------------------------------------
	// Datapath registers
	// ------------------------------------------------------------------
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (step.active)
		begin
			coeff_q <= coeff_sel;
			value_q <= value_sel;
		end
		if (acc_en)
			acc <= acc_first ? prod_fix : fix_t'(acc + prod_fix);	// Wraps at 18 bits
	end

	// Pipeline control and output history
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			acc_en    <= 1'b0;
			acc_first <= 1'b0;
			y_n1      <= '0;
			y_n2      <= '0;
		end
		else
		begin
			acc_en    <= step.active;
			acc_first <= step.active && (step.tap == TAP_B1);
			if (step.update)
			begin
				y_n1 <= fix_t'(acc << OUT_SHIFT);	// Undo half-scale coeffs
				y_n2 <= y_n1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/filter_sequencer.sv
/*
 * Filter sequencer
 *   LR clock register and one-shot detector
 *   FSM stepping through the five taps of a frame
 *   capture pulse and update strobe for the histories
 */

`timescale 1ns/1ns
`default_nettype none

module filter_sequencer
	import audio_filter_pkg::*;
(
	input  logic      AUD_CTRL_CLK,
	input  logic      reset,
	input  logic      dac_lrck,	// Plain level from the codec side
	output mac_step_t step,
	output logic      capture	// Load new sample into history
);

	seq_state_t state;
	logic       lrck_q;	// Registered LR clock level
	logic       armed;	// One-shot memory, level seen low
	logic       upd_q;	// Update strobe, one cycle behind ST_UPDATE

	// Frame start, only from idle with the one-shot armed
	assign capture = (state == ST_IDLE) && lrck_q && armed;

	// ------------------------------------------------------------------
	// State register
	// ------------------------------------------------------------------
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			state  <= ST_IDLE;
			lrck_q <= 1'b0;
			armed  <= 1'b0;
			upd_q  <= 1'b0;
		end
		else
		begin
			lrck_q <= dac_lrck;
			// Last product lands in the accumulator during ST_UPDATE,
			// so the store happens one cycle later
			upd_q  <= (state == ST_UPDATE);
			case (state)
				ST_IDLE:
				begin
					if (capture)
					begin
						state <= ST_B1;
						armed <= 1'b0;	// Wait for low again
					end
					else if (!lrck_q)
						armed <= 1'b1;	// Re-arm the one-shot
				end
				ST_B1:     state <= ST_B2;
				ST_B2:     state <= ST_B3;
				ST_B3:     state <= ST_A2;
				ST_A2:     state <= ST_A3;
				ST_A3:     state <= ST_UPDATE;
				default:   state <= ST_IDLE;	// ST_UPDATE and unused codes
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Step decode, tap index is the state itself
	// ------------------------------------------------------------------
	always_comb
	begin
		step.active = (state >= ST_B1) && (state <= ST_A3);
		step.tap    = step.active ? tap_t'(3'(state - 3'd1)) : TAP_B1;
		step.update = upd_q;
	end

endmodule

`default_nettype wire

// File: hdl/sample_history.sv
/*
 * Shared input history for both sections
 *   x(n) loaded from the codec sample on capture
 *   x(n-1), x(n-2) shifted on update
 */

`timescale 1ns/1ns
`default_nettype none

module sample_history
	import audio_filter_pkg::*;
(
	input  logic    AUD_CTRL_CLK,
	input  logic    reset,
	input  logic    capture,	// Frame start
	input  logic    update,	// End of frame
	input  sample_t audio_in,
	output x_hist_t hist
);

	fix_t x_scaled;

	// 16-bit sample into 2.16, two zero LSBs
	assign x_scaled = {audio_in, {(FIX_W-SAMPLE_W){1'b0}}};

	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			hist <= '0;	// Start from silence
		end
		else
		begin
			if (capture)
				hist.x_n <= x_scaled;

			// Age the history once both sections are done with it
			if (update)
			begin
				hist.x_n1 <= hist.x_n;
				hist.x_n2 <= hist.x_n1;
			end
		end
	end

endmodule

`default_nettype wire

// File: project.f
hdl/audio_filter_pkg.sv
hdl/filter_sequencer.sv
hdl/sample_history.sv
hdl/biquad_mac.sv
hdl/audio_filter_top.sv
verif/audio_filter_asserts.sv
verif/audio_filter_tb.sv

// File: verif/audio_filter_asserts.sv
/*
 * Concurrent assertions on the filter sequencer
 *   frame length, capture only from idle
 *   return to idle after the update strobe
 */

`timescale 1ns/1ns
`default_nettype none

module audio_filter_asserts
	import audio_filter_pkg::*;
(
	input logic       AUD_CTRL_CLK,
	input logic       reset,
	input seq_state_t state,
	input logic       capture,
	input mac_step_t  step
);

	// Failure counts, one per property
	int err_done    = 0;
	int err_capture = 0;
	int err_update  = 0;

	// Frame over seven cycles after its start
	frame_done: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		capture |-> ##7 (state == ST_IDLE))
	else
	begin
		$error("sequencer not back in ST_IDLE 7 cycles after capture");
		err_done++;
	end

	// Start only from a settled idle, never on the store cycle
	capture_idle: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		capture |-> ($past(state) == ST_IDLE))
	else
	begin
		$error("capture raised outside ST_IDLE or on the store cycle");
		err_capture++;
	end

	update_idle: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		step.update |=> (state == ST_IDLE))	// No restart on the store cycle
	else
	begin
		$error("update strobe not followed by ST_IDLE");
		err_update++;
	end

endmodule

`default_nettype wire

// File: verif/audio_filter_tb.sv
/*
 * Testbench for the audio filter core
 *   clock, reset and LR clock stimulus
 *   stimulus table of fixed and LCG rows
 *   fixed-point reference model of both sections
 *   per-frame output checks and closing summary
 */

`timescale 1ns/1ns
`default_nettype none

module audio_filter_tb
	import audio_filter_pkg::*;
();

	localparam int NUM_ROWS   = 30;
	localparam int START_WAIT = 8;	// Cycles allowed from LR rise to capture

	// Lowpass, A terms negated
	localparam fix_t LP_B1 = 18'h0_0524;
	localparam fix_t LP_B2 = 18'h0_0A48;
	localparam fix_t LP_B3 = 18'h0_0524;
	localparam fix_t LP_A2 = 18'h1_8F9E;
	localparam fix_t LP_A3 = 18'h3_5BD1;
	// Bandpass at half scale
	localparam fix_t BP_B1 = 18'h0_0956;
	localparam fix_t BP_B2 = 18'h0_0000;
	localparam fix_t BP_B3 = 18'h3_F6AA;
	localparam fix_t BP_A2 = 18'h0_DBEF;
	localparam fix_t BP_A3 = 18'h3_92AE;

	typedef struct packed {
		sample_t    sample;
		logic [7:0] hold;	// Cycles dac_lrck stays high
		logic       glitch;	// Second rise inside the frame
		sample_t    exp_l;
		sample_t    exp_r;
	} row_t;

	logic        AUD_CTRL_CLK;
	logic        reset;
	logic        dac_lrck;
	sample_t     audio_in;
	sample_t     audio_out_l, audio_out_r;
	row_t        rows [NUM_ROWS];
	logic [31:0] lcg_state = 32'd53;
	sample_t     prev_l, prev_r;	// Outputs of the last frame
	int          check_count = 0;
	int          error_count = 0;
	logic        timed_out;

	audio_filter_top i_audio_filter_top (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.dac_lrck     (dac_lrck),
		.audio_in     (audio_in),
		.audio_out_l  (audio_out_l),
		.audio_out_r  (audio_out_r)
	);

	bind filter_sequencer audio_filter_asserts u_seq_asserts (
		.AUD_CTRL_CLK (AUD_CTRL_CLK),
		.reset        (reset),
		.state        (state),
		.capture      (capture),
		.step         (step)
	);

	always #50 AUD_CTRL_CLK = ~AUD_CTRL_CLK;	// 100 ns period

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// 2.16 product, sign then bits 32..16
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		prod_t full;
		full = prod_t'(a) * prod_t'(b);
		return {full[35], full[32:16]};
	endfunction

	function automatic fix_t section_out(input fix_t b1, b2, b3, a2, a3,
		input fix_t x0, x1, x2, y1, y2, input int shift);
		fix_t sum;
		sum = fix_mul(b1, x0);
		sum = sum + fix_mul(b2, x1);	// Wraps at 18 bits
		sum = sum + fix_mul(b3, x2);
		sum = sum + fix_mul(a2, y1);
		sum = sum + fix_mul(a3, y2);
		return fix_t'(sum << shift);
	endfunction

	// Top 16 bits, inverted
	function automatic sample_t to_codec(input fix_t y);
		sample_t kept;
		kept = y[17:2];
		return -kept;
	endfunction

	function automatic logic lrck_level(input row_t row, input int t);
		return (t < int'(row.hold)) || (row.glitch && (t == 5 || t == 6));
	endfunction

	task automatic build_table();
		logic [31:0] r;
		fix_t x0, lp_y, bp_y;
		fix_t x1 = '0, x2 = '0;
		fix_t lp1 = '0, lp2 = '0, bp1 = '0, bp2 = '0;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			r = lcg_next();
			rows[i].glitch = (i == 4) || (i == 14);
			rows[i].hold   = (i == 3) ? 8'd20 : (i == 9) ? 8'd12 : rows[i].glitch ? 8'd3 : 8'd1;
			if (i == 1)
				rows[i].sample = 16'h4000;	// Impulse, then zeros
			else if (i >= 6 && i < 12)
				rows[i].sample = 16'h7FFF;	// Positive full-scale step
			else if (i >= 12 && i < 18)
				rows[i].sample = 16'h8000;	// Negative full-scale step
			else if (i >= 18)
			begin
				rows[i].sample = r[31:16];
				rows[i].glitch = r[5];
				rows[i].hold   = r[5] ? 8'd3 : 8'(r[11:8]) + 8'd1;
			end
			else
				rows[i].sample = '0;
			x0   = {rows[i].sample, 2'b00};
			lp_y = section_out(LP_B1, LP_B2, LP_B3, LP_A2, LP_A3, x0, x1, x2, lp1, lp2, 0);
			bp_y = section_out(BP_B1, BP_B2, BP_B3, BP_A2, BP_A3, x0, x1, x2, bp1, bp2, 1);
			rows[i].exp_l = to_codec(lp_y);
			rows[i].exp_r = to_codec(bp_y);
			lp2 = lp1;
			lp1 = lp_y;
			bp2 = bp1;
			bp1 = bp_y;
			x2  = x1;
			x1  = x0;
		end
	endtask

	// ------------------------------------------------------------------
	// Driving and checking
	// ------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge AUD_CTRL_CLK);
		#5;	// Drive and sample here
	endtask

	task automatic check_value(input string what, input sample_t got, input sample_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs(input sample_t exp_l, input sample_t exp_r);
		check_value("audio_out_l", audio_out_l, exp_l);
		check_value("audio_out_r", audio_out_r, exp_r);
		check_value("capture", {15'd0, i_audio_filter_top.capture}, 16'd0);	// No extra frame
	endtask

	task automatic run_row(input int idx);
		row_t row;
		int   t;
		logic found;
		row      = rows[idx];
		t        = 0;
		found    = 1'b0;
		audio_in = row.sample;
		dac_lrck = lrck_level(row, t);
		while (!found && t < START_WAIT)
		begin
			next_cycle();
			t++;
			dac_lrck = lrck_level(row, t);
			found    = i_audio_filter_top.capture;	// Edge E comes next
		end
		if (!found)
		begin
			$display("test %0d: no frame start within %0d cycles of the LR rise", idx, START_WAIT);
			timed_out = 1'b1;
			return;
		end
		// n = 1..7 are E..E+6 with old outputs, new ones from E+7
		for (int n = 1; n <= 8 || t < int'(row.hold) + 5; n++)
		begin
			next_cycle();
			t++;
			dac_lrck = lrck_level(row, t);
			if (n <= 7)
				check_outputs(prev_l, prev_r);
			else
				check_outputs(row.exp_l, row.exp_r);
		end
		prev_l = row.exp_l;
		prev_r = row.exp_r;
	endtask

	initial
	begin
		int errs;
		int assert_fails;
		AUD_CTRL_CLK = 1'b0;
		reset        = 1'b1;
		dac_lrck     = 1'b0;
		audio_in     = '0;
		prev_l       = '0;
		prev_r       = '0;
		timed_out    = 1'b0;
		build_table();
		repeat (4) next_cycle();
		reset = 1'b0;
		errs  = error_count;
		repeat (10)
		begin
			next_cycle();
			check_outputs('0, '0);	// Silent while LR clock low
		end
		$display("reset test: %0d errors", error_count - errs);
		for (int i = 0; i < NUM_ROWS && !timed_out; i++)
		begin
			errs = error_count;
			run_row(i);
			$display("test %0d: sample %0d left %0d right %0d hold %0d glitch %0d: %s", i,
				rows[i].sample, rows[i].exp_l, rows[i].exp_r, rows[i].hold, rows[i].glitch,
				timed_out ? "timeout" : (error_count == errs) ? "ok" : "mismatch");
		end
		assert_fails = i_audio_filter_top.u_sequencer.u_seq_asserts.err_done
			+ i_audio_filter_top.u_sequencer.u_seq_asserts.err_capture
			+ i_audio_filter_top.u_sequencer.u_seq_asserts.err_update;
		$display("summary: %0d checks, %0d errors, %0d assertion failures",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0 && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
